// ==== hdl/spi_pkg.sv ====
package spi_pkg;

    localparam int ADDR_W      = 16;            // Address carried by SPI frames
    localparam int MEM_AW      = 8;             // Low address bits that index the memory
    localparam int MEM_WORDS   = 1 << MEM_AW;
    localparam int DATA_W      = 8;
    localparam int SYNC_STAGES = 2;             // Flops per pin synchronizer

    // Command byte bits 1:0
    typedef enum logic [1:0] {
        MODE_CMD       = 2'b00,
        MODE_DATA      = 2'b01,
        MODE_ADDR      = 2'b10,
        MODE_ADDR_DATA = 2'b11
    } frame_mode_e;

    typedef enum logic [1:0] {
        RX_IDLE  = 2'd0,
        RX_TRANS = 2'd1,
        RX_RST   = 2'd2
    } rx_state_e;

    typedef enum logic [1:0] {
        APB_IDLE   = 2'd0,
        APB_SETUP  = 2'd1,
        APB_ACCESS = 2'd2
    } apb_state_e;

endpackage

// ==== hdl/spi_frame_rx.sv ====
`timescale 1ns/100ps

module spi_frame_rx (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       sclk,
    input  logic                       ss,
    input  logic                       mosi,
    input  logic [spi_pkg::DATA_W-1:0] tx_data,
    input  logic [spi_pkg::DATA_W-1:0] status,
    output logic                       miso,
    output logic                       busy,
    output logic                       frame_err,
    output logic                       cmd_strobe,
    output logic                       cmd_read,
    output logic                       addr_strobe,
    output logic [spi_pkg::ADDR_W-1:0] addr,
    output logic                       wr_strobe,
    output logic [spi_pkg::DATA_W-1:0] wr_data,
    output logic                       rd_strobe,
    output logic                       frame_end
);

    logic [spi_pkg::SYNC_STAGES-1:0] sclk_sync;
    logic [spi_pkg::SYNC_STAGES-1:0] ss_sync;
    logic [spi_pkg::SYNC_STAGES-1:0] mosi_sync;
    logic                            sclk_s;
    logic                            ss_s;
    logic                            mosi_s;
    logic                            sclk_d;
    logic                            sclk_rise;
    logic                            sclk_fall;

    spi_pkg::rx_state_e              state;
    spi_pkg::frame_mode_e            mode;
    logic [spi_pkg::DATA_W-1:0]      rx_shift;
    logic [spi_pkg::DATA_W-1:0]      status_q;
    logic [3:0]                      bit_cnt;   // Bits sampled in the current byte
    logic [2:0]                      tx_idx;    // Falling edges seen in the current byte
    logic [1:0]                      rem;       // Bytes still expected
    logic                            cmd_done;
    logic                            cont;
    logic                            write_f;
    logic                            addr_hi_now;
    logic                            addr_lo_now;
    logic                            data_now;
    logic                            rd_phase;

    assign sclk_s    = sclk_sync[spi_pkg::SYNC_STAGES-1];
    assign ss_s      = ss_sync[spi_pkg::SYNC_STAGES-1];
    assign mosi_s    = mosi_sync[spi_pkg::SYNC_STAGES-1];
    assign sclk_rise = sclk_s & ~sclk_d;
    assign sclk_fall = ~sclk_s & sclk_d;

    // Which byte of the frame is on the wire
    assign addr_hi_now = cmd_done && ((mode == spi_pkg::MODE_ADDR_DATA && rem == 2'd3) ||
                                      (mode == spi_pkg::MODE_ADDR && rem == 2'd2));
    assign addr_lo_now = cmd_done && ((mode == spi_pkg::MODE_ADDR_DATA && rem == 2'd2) ||
                                      (mode == spi_pkg::MODE_ADDR && rem == 2'd1));
    assign data_now    = cmd_done && rem == 2'd1 &&
                         (mode == spi_pkg::MODE_DATA || mode == spi_pkg::MODE_ADDR_DATA);
    assign rd_phase    = data_now && !write_f;

    assign busy = (state == spi_pkg::RX_TRANS);

    // Status during the command byte, prefetched byte during a read byte, MSB first
    assign miso = busy && (cmd_done ? (rd_phase && tx_data[~tx_idx]) : status_q[~tx_idx]);

    always_ff @(posedge clk) begin
        if (!rst) begin
            sclk_sync <= '0;
            ss_sync   <= '1;
            sclk_d    <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[spi_pkg::SYNC_STAGES-2:0], sclk};
            ss_sync   <= {ss_sync[spi_pkg::SYNC_STAGES-2:0], ss};
            sclk_d    <= sclk_s;
        end
    end

    always_ff @(posedge clk) begin
        mosi_sync <= {mosi_sync[spi_pkg::SYNC_STAGES-2:0], mosi};
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state       <= spi_pkg::RX_RST;
            frame_err   <= 1'b0;
            cmd_strobe  <= 1'b0;
            addr_strobe <= 1'b0;
            wr_strobe   <= 1'b0;
            rd_strobe   <= 1'b0;
            frame_end   <= 1'b0;
        end else begin
            cmd_strobe  <= 1'b0;
            addr_strobe <= 1'b0;
            wr_strobe   <= 1'b0;
            rd_strobe   <= 1'b0;
            frame_end   <= 1'b0;
            case (state)
                spi_pkg::RX_IDLE: begin
                    if (!ss_s) begin
                        state    <= spi_pkg::RX_TRANS;
                        status_q <= status;     // Frozen for the whole command byte
                    end
                end
                spi_pkg::RX_TRANS: begin
                    if (ss_s) begin
                        // Partial byte or missing bytes of a single frame
                        state     <= spi_pkg::RX_RST;
                        frame_end <= 1'b1;
                        frame_err <= (bit_cnt != 4'd0) || (!cont && rem != 2'd0);
                    end else begin
                        if (sclk_rise) begin
                            rx_shift <= {rx_shift[spi_pkg::DATA_W-2:0], mosi_s};
                            bit_cnt  <= bit_cnt + 4'd1;
                        end
                        if (sclk_fall) begin
                            tx_idx <= tx_idx + 3'd1;
                            if (bit_cnt == 4'd8) begin
                                bit_cnt <= 4'd0;
                                if (!cmd_done) begin
                                    cmd_done   <= 1'b1;
                                    mode       <= spi_pkg::frame_mode_e'(rx_shift[1:0]);
                                    cont       <= rx_shift[2];
                                    write_f    <= rx_shift[3];
                                    rem        <= rx_shift[1:0];    // Mode is also the byte count
                                    cmd_strobe <= 1'b1;
                                    cmd_read   <= !rx_shift[3] && rx_shift[0];
                                end else if (addr_hi_now) begin
                                    addr[spi_pkg::ADDR_W-1:spi_pkg::DATA_W] <= rx_shift;
                                    rem <= rem - 2'd1;
                                end else if (addr_lo_now) begin
                                    addr[spi_pkg::DATA_W-1:0] <= rx_shift;
                                    addr_strobe <= 1'b1;
                                    if (mode == spi_pkg::MODE_ADDR && cont)
                                        rem <= 2'd2;        // Next address pair
                                    else
                                        rem <= rem - 2'd1;
                                end else if (data_now) begin
                                    if (write_f) begin
                                        wr_strobe <= 1'b1;
                                        wr_data   <= rx_shift;
                                    end else begin
                                        rd_strobe <= 1'b1;
                                    end
                                    rem <= cont ? 2'd1 : 2'd0;
                                end
                                // Extra bytes after a complete frame are ignored
                            end
                        end
                    end
                end
                spi_pkg::RX_RST: begin
                    bit_cnt  <= 4'd0;
                    tx_idx   <= 3'd0;
                    rem      <= 2'd0;
                    cmd_done <= 1'b0;
                    cont     <= 1'b0;
                    write_f  <= 1'b0;
                    mode     <= spi_pkg::MODE_CMD;
                    if (ss_s)
                        state <= spi_pkg::RX_IDLE;
                end
                default: state <= spi_pkg::RX_RST;
            endcase
        end
    end

    a_one_event: assert property (@(posedge clk) disable iff (!rst)
        $onehot0({cmd_strobe, addr_strobe, wr_strobe, rd_strobe, frame_end}));

    a_event_in_frame: assert property (@(posedge clk) disable iff (!rst)
        (cmd_strobe || addr_strobe || wr_strobe || rd_strobe) |-> state == spi_pkg::RX_TRANS);

endmodule

// ==== hdl/spi_bus_master.sv ====
`timescale 1ns/100ps

module spi_bus_master (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cmd_strobe,
    input  logic                       cmd_read,
    input  logic                       addr_strobe,
    input  logic [spi_pkg::ADDR_W-1:0] addr,
    input  logic                       wr_strobe,
    input  logic [spi_pkg::DATA_W-1:0] wr_data,
    input  logic                       rd_strobe,
    input  logic                       frame_end,
    input  logic                       frame_err,
    output logic [spi_pkg::DATA_W-1:0] tx_data,
    output logic [spi_pkg::DATA_W-1:0] status,
    output logic                       m_psel,
    output logic                       m_penable,
    output logic                       m_pwrite,
    output logic [spi_pkg::MEM_AW-1:0] m_paddr,
    output logic [spi_pkg::DATA_W-1:0] m_pwdata,
    input  logic [spi_pkg::DATA_W-1:0] m_prdata,
    input  logic                       m_pready
);

    spi_pkg::apb_state_e          state;
    logic [spi_pkg::ADDR_W-1:0]   ptr;
    logic [spi_pkg::MEM_AW-1:0]   wr_addr;
    logic [spi_pkg::DATA_W-1:0]   wr_buf;
    logic [spi_pkg::DATA_W-2:0]   wr_cnt;       // SPI writes, wraps at 128
    logic                         wr_pend;
    logic                         rd_pend;
    logic                         read_mode;
    logic                         err_q;        // Error flag of the previous frame

    assign status    = {err_q, wr_cnt};
    assign m_psel    = (state != spi_pkg::APB_IDLE);
    assign m_penable = (state == spi_pkg::APB_ACCESS);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= spi_pkg::APB_IDLE;
            ptr       <= '0;
            wr_cnt    <= '0;
            wr_pend   <= 1'b0;
            rd_pend   <= 1'b0;
            read_mode <= 1'b0;
            err_q     <= 1'b0;
            tx_data   <= '0;
        end else begin
            case (state)
                spi_pkg::APB_IDLE: begin
                    if (wr_pend || rd_pend)
                        state <= spi_pkg::APB_SETUP;
                end
                spi_pkg::APB_SETUP: state <= spi_pkg::APB_ACCESS;
                spi_pkg::APB_ACCESS: begin
                    if (m_pready) begin
                        state <= spi_pkg::APB_IDLE;
                        if (m_pwrite) begin
                            wr_pend <= 1'b0;
                        end else begin
                            rd_pend <= 1'b0;
                            tx_data <= m_prdata;
                        end
                    end
                end
                default: state <= spi_pkg::APB_IDLE;
            endcase

            // New requests override a completion in the same cycle
            if (cmd_strobe) begin
                read_mode <= cmd_read;
                if (cmd_read)
                    rd_pend <= 1'b1;        // Mode 1 reads at the current pointer
            end
            if (addr_strobe) begin
                ptr <= addr;
                if (read_mode)
                    rd_pend <= 1'b1;
            end
            if (wr_strobe) begin
                wr_pend <= 1'b1;
                ptr     <= ptr + 1'b1;
                wr_cnt  <= wr_cnt + 1'b1;
            end
            if (rd_strobe) begin
                ptr     <= ptr + 1'b1;
                rd_pend <= 1'b1;            // Prefetch for the next read byte
            end
            if (frame_end)
                err_q <= frame_err;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_strobe) begin
            wr_buf  <= wr_data;
            wr_addr <= ptr[spi_pkg::MEM_AW-1:0];
        end
        // Writes go first; a read uses the pointer as it is at issue
        if (state == spi_pkg::APB_IDLE) begin
            m_pwrite <= wr_pend;
            m_paddr  <= wr_pend ? wr_addr : ptr[spi_pkg::MEM_AW-1:0];
            m_pwdata <= wr_buf;
        end
    end

    a_apb_hold: assert property (@(posedge clk) disable iff (!rst)
        m_psel && !m_pready |=> $stable({m_pwrite, m_paddr, m_pwdata}));

endmodule

// ==== hdl/apb_arbiter.sv ====
`timescale 1ns/100ps

module apb_arbiter (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       m_psel,
    input  logic                       m_penable,
    input  logic                       m_pwrite,
    input  logic [spi_pkg::MEM_AW-1:0] m_paddr,
    input  logic [spi_pkg::DATA_W-1:0] m_pwdata,
    output logic [spi_pkg::DATA_W-1:0] m_prdata,
    output logic                       m_pready,
    input  logic                       h_psel,
    input  logic                       h_penable,
    input  logic                       h_pwrite,
    input  logic [spi_pkg::MEM_AW-1:0] h_paddr,
    input  logic [spi_pkg::DATA_W-1:0] h_pwdata,
    output logic [spi_pkg::DATA_W-1:0] h_prdata,
    output logic                       h_pready,
    output logic                       s_psel,
    output logic                       s_penable,
    output logic                       s_pwrite,
    output logic [spi_pkg::MEM_AW-1:0] s_paddr,
    output logic [spi_pkg::DATA_W-1:0] s_pwdata,
    input  logic [spi_pkg::DATA_W-1:0] s_prdata,
    input  logic                       s_pready
);

    spi_pkg::apb_state_e state;
    logic                grant_h;   // Host owns the current transfer
    logic                last_h;    // Host had the last transfer
    logic                pick_h;
    logic                sel_h;
    logic                idle;
    logic                access;

    assign idle   = (state == spi_pkg::APB_IDLE);
    assign access = (state == spi_pkg::APB_ACCESS);

    // Round robin only matters when both ask at once
    assign pick_h = h_psel && (!m_psel || !last_h);
    assign sel_h  = idle ? pick_h : grant_h;

    // A free bus passes the requester's setup phase straight through
    assign s_psel    = idle ? (m_psel || h_psel) : 1'b1;
    assign s_penable = access && (sel_h ? h_penable : m_penable);
    assign s_pwrite  = sel_h ? h_pwrite : m_pwrite;
    assign s_paddr   = sel_h ? h_paddr : m_paddr;
    assign s_pwdata  = sel_h ? h_pwdata : m_pwdata;

    assign m_prdata = s_prdata;
    assign h_prdata = s_prdata;
    assign m_pready = access && !grant_h && s_pready;
    assign h_pready = access && grant_h && s_pready;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state   <= spi_pkg::APB_IDLE;
            grant_h <= 1'b0;
            last_h  <= 1'b1;
        end else begin
            case (state)
                spi_pkg::APB_IDLE: begin
                    if (m_psel || h_psel) begin
                        state   <= spi_pkg::APB_ACCESS;
                        grant_h <= pick_h;
                    end
                end
                spi_pkg::APB_SETUP: state <= spi_pkg::APB_ACCESS;
                spi_pkg::APB_ACCESS: begin
                    if (s_pready) begin
                        last_h <= grant_h;
                        if (grant_h ? m_psel : h_psel) begin
                            state   <= spi_pkg::APB_SETUP;    // Waiting peer goes next
                            grant_h <= !grant_h;
                        end else begin
                            state <= spi_pkg::APB_IDLE;
                        end
                    end
                end
                default: state <= spi_pkg::APB_IDLE;
            endcase
        end
    end

    // Ready only reaches a requester that sits in its access phase
    a_m_ready: assert property (@(posedge clk) disable iff (!rst)
        m_pready |-> m_psel && m_penable);

    a_h_ready: assert property (@(posedge clk) disable iff (!rst)
        h_pready |-> h_psel && h_penable);

endmodule

// ==== hdl/reg_mem.sv ====
`timescale 1ns/100ps

module reg_mem (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       s_psel,
    input  logic                       s_penable,
    input  logic                       s_pwrite,
    input  logic [spi_pkg::MEM_AW-1:0] s_paddr,
    input  logic [spi_pkg::DATA_W-1:0] s_pwdata,
    output logic [spi_pkg::DATA_W-1:0] s_prdata,
    output logic                       s_pready
);

    logic [spi_pkg::DATA_W-1:0] mem [spi_pkg::MEM_WORDS];

    // Ready in every access cycle, set from the setup cycle
    always_ff @(posedge clk) begin
        if (!rst)
            s_pready <= 1'b0;
        else
            s_pready <= s_psel && !s_penable;
    end

    always_ff @(posedge clk) begin
        if (s_psel && !s_penable)
            s_prdata <= mem[s_paddr];   // Valid by the access cycle
        if (s_psel && s_penable && s_pwrite && s_pready)
            mem[s_paddr] <= s_pwdata;
    end

endmodule

// ==== hdl/spi_mem_bridge.sv ====
`timescale 1ns/100ps

module spi_mem_bridge (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       sclk,
    input  logic                       ss,
    input  logic                       mosi,
    output logic                       miso,
    output logic                       busy,
    output logic                       frame_err,
    input  logic                       h_psel,
    input  logic                       h_penable,
    input  logic                       h_pwrite,
    input  logic [spi_pkg::MEM_AW-1:0] h_paddr,
    input  logic [spi_pkg::DATA_W-1:0] h_pwdata,
    output logic [spi_pkg::DATA_W-1:0] h_prdata,
    output logic                       h_pready
);

    // Receiver to bus master
    logic                       cmd_strobe;
    logic                       cmd_read;
    logic                       addr_strobe;
    logic [spi_pkg::ADDR_W-1:0] addr;
    logic                       wr_strobe;
    logic [spi_pkg::DATA_W-1:0] wr_data;
    logic                       rd_strobe;
    logic                       frame_end;
    logic [spi_pkg::DATA_W-1:0] tx_data;
    logic [spi_pkg::DATA_W-1:0] status;

    // Bus master side of the arbiter
    logic                       m_psel;
    logic                       m_penable;
    logic                       m_pwrite;
    logic [spi_pkg::MEM_AW-1:0] m_paddr;
    logic [spi_pkg::DATA_W-1:0] m_pwdata;
    logic [spi_pkg::DATA_W-1:0] m_prdata;
    logic                       m_pready;

    // Memory side
    logic                       s_psel;
    logic                       s_penable;
    logic                       s_pwrite;
    logic [spi_pkg::MEM_AW-1:0] s_paddr;
    logic [spi_pkg::DATA_W-1:0] s_pwdata;
    logic [spi_pkg::DATA_W-1:0] s_prdata;
    logic                       s_pready;

    spi_frame_rx u_rx (
        .clk(clk), .rst(rst), .sclk(sclk), .ss(ss), .mosi(mosi),
        .tx_data(tx_data), .status(status),
        .miso(miso), .busy(busy), .frame_err(frame_err),
        .cmd_strobe(cmd_strobe), .cmd_read(cmd_read),
        .addr_strobe(addr_strobe), .addr(addr),
        .wr_strobe(wr_strobe), .wr_data(wr_data),
        .rd_strobe(rd_strobe), .frame_end(frame_end)
    );

    spi_bus_master u_master (
        .clk(clk), .rst(rst),
        .cmd_strobe(cmd_strobe), .cmd_read(cmd_read),
        .addr_strobe(addr_strobe), .addr(addr),
        .wr_strobe(wr_strobe), .wr_data(wr_data),
        .rd_strobe(rd_strobe), .frame_end(frame_end), .frame_err(frame_err),
        .tx_data(tx_data), .status(status),
        .m_psel(m_psel), .m_penable(m_penable), .m_pwrite(m_pwrite),
        .m_paddr(m_paddr), .m_pwdata(m_pwdata),
        .m_prdata(m_prdata), .m_pready(m_pready)
    );

    apb_arbiter u_arb (
        .clk(clk), .rst(rst),
        .m_psel(m_psel), .m_penable(m_penable), .m_pwrite(m_pwrite),
        .m_paddr(m_paddr), .m_pwdata(m_pwdata),
        .m_prdata(m_prdata), .m_pready(m_pready),
        .h_psel(h_psel), .h_penable(h_penable), .h_pwrite(h_pwrite),
        .h_paddr(h_paddr), .h_pwdata(h_pwdata),
        .h_prdata(h_prdata), .h_pready(h_pready),
        .s_psel(s_psel), .s_penable(s_penable), .s_pwrite(s_pwrite),
        .s_paddr(s_paddr), .s_pwdata(s_pwdata),
        .s_prdata(s_prdata), .s_pready(s_pready)
    );

    reg_mem u_mem (
        .clk(clk), .rst(rst),
        .s_psel(s_psel), .s_penable(s_penable), .s_pwrite(s_pwrite),
        .s_paddr(s_paddr), .s_pwdata(s_pwdata),
        .s_prdata(s_prdata), .s_pready(s_pready)
    );

endmodule

// ==== tb/tb_tasks.svh ====
// Xorshift32 step giving the next state
function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
endtask

// One host APB transfer with a bounded wait for pready
task automatic host_xfer(input logic write, input logic [7:0] a, input logic [7:0] wd,
                         output logic [7:0] rd, output logic done);
    int waited;
    waited = 0;
    done   = 1'b0;
    rd     = 8'h00;
    @(posedge clk);
    h_psel    <= 1'b1;          // Setup phase
    h_penable <= 1'b0;
    h_pwrite  <= write;
    h_paddr   <= a;
    h_pwdata  <= wd;
    @(posedge clk);
    h_penable <= 1'b1;
    while (!done && waited < HOST_WAIT) begin
        @(negedge clk);
        if (h_pready) begin
            done = 1'b1;
            rd   = h_prdata;
        end
        waited++;
    end
    @(posedge clk);
    h_psel    <= 1'b0;
    h_penable <= 1'b0;
endtask

task automatic host_write(input logic [7:0] a, input logic [7:0] d);
    logic [7:0] rd;
    logic       done;
    host_xfer(1'b1, a, d, rd, done);
    assert (done) else begin
        $display("Host write to address %02h never got pready", a);
        errors++;
    end
    mem_model[a] = d;
endtask

task automatic host_check(input logic [7:0] a);
    logic [7:0] rd;
    logic       done;
    host_xfer(1'b0, a, 8'h00, rd, done);
    assert (done) else begin
        $display("Host read from address %02h never got pready", a);
        errors++;
    end
    check_byte($sformatf("h_prdata[%02h]", a), mem_model[a], rd);
endtask

// Mode 0 byte with MISO taken at the end of the high phase
task automatic spi_byte(input logic [7:0] tx, input int nbits, output logic [7:0] rx);
    rx = 8'h00;
    for (int i = 7; i > 7 - nbits; i--) begin
        mosi <= tx[i];              // Changes with the falling edge
        wait_cycles(HALF);
        sclk <= 1'b1;
        wait_cycles(HALF - 1);
        @(negedge clk);
        rx[i] = miso;
        @(posedge clk);
        sclk <= 1'b0;
    end
endtask

// Frame from tx_bytes where a nonzero abort_bits cuts the last byte short
task automatic spi_frame(input int nbytes, input int abort_bits);
    int nb;
    @(posedge clk);
    ss <= 1'b0;
    wait_cycles(HALF - 1);
    @(negedge clk);
    check_byte("busy", 8'd1, {7'd0, busy});   // SS low has passed the synchronizer
    @(posedge clk);
    for (int b = 0; b < nbytes; b++) begin
        nb = (b == nbytes - 1 && abort_bits != 0) ? abort_bits : 8;
        spi_byte(tx_bytes[b], nb, rx_bytes[b]);
    end
    wait_cycles(HALF);
    ss <= 1'b1;
    wait_cycles(GAP);
endtask

// ==== tb/tb_spi_mem_bridge.sv ====
`timescale 1ns/100ps

module tb_spi_mem_bridge;

    localparam int HALF         = 5;        // SCLK at clk/10
    localparam int GAP          = 12;       // Idle cycles after a frame
    localparam int HOST_WAIT    = 32;
    localparam int MAX_BYTES    = 19;       // Command, address and 16 data bytes
    localparam int N_FRAMES     = 40;
    localparam int FRAME_CYCLES = 16 * HALF * MAX_BYTES + 2 * HALF + GAP + 2;
    localparam int HOST_CYCLES  = 5 * spi_pkg::MEM_WORDS * (HOST_WAIT + 4);
    localparam int WATCHDOG     = N_FRAMES * FRAME_CYCLES + HOST_CYCLES + 5000;

    logic        clk;
    logic        rst;
    logic        sclk;
    logic        ss;
    logic        mosi;
    logic        miso;
    logic        busy;
    logic        frame_err;
    logic        h_psel;
    logic        h_penable;
    logic        h_pwrite;
    logic [7:0]  h_paddr;
    logic [7:0]  h_pwdata;
    logic [7:0]  h_prdata;
    logic        h_pready;

    // Reference model
    logic [7:0]  mem_model [spi_pkg::MEM_WORDS];
    logic        prev_err;
    logic [6:0]  wr_count;
    logic [15:0] ptr_model;

    logic [7:0]  tx_bytes [MAX_BYTES];
    logic [7:0]  rx_bytes [MAX_BYTES];
    logic [31:0] seed;
    logic [31:0] host_seed;     // Separate stream for the concurrent host process
    logic        spi_done;
    int          errors;
    int          checks;
    int          start_errors;
    int          tests_run;
    int          tests_failed;
    int          host_count;

    spi_mem_bridge spi_mem_bridge_inst (
        .clk(clk), .rst(rst), .sclk(sclk), .ss(ss), .mosi(mosi), .miso(miso),
        .busy(busy), .frame_err(frame_err),
        .h_psel(h_psel), .h_penable(h_penable), .h_pwrite(h_pwrite),
        .h_paddr(h_paddr), .h_pwdata(h_pwdata), .h_prdata(h_prdata), .h_pready(h_pready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG);
        $display(">>> FAIL");
        $finish;
    end

    `include "tb_tasks.svh"

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
        checks++;
        assert (got == exp) else begin
            $display("[ERROR] %0t %s expected %02h got %02h", $time, name, exp, got);
            errors++;
        end
    endtask

    // Status byte and frame_err follow every frame
    task automatic run_frame(input int nbytes, input int abort_bits);
        logic [7:0] exp_status;
        exp_status = {prev_err, wr_count};
        spi_frame(nbytes, abort_bits);
        check_byte("miso status", exp_status, rx_bytes[0]);
        prev_err = (abort_bits != 0);
        check_byte("frame_err", {7'd0, prev_err}, {7'd0, frame_err});
    endtask

    task automatic write_frame(input logic [15:0] a, input int len);
        tx_bytes[0] = 8'h0f;    // Write, cont, mode 3
        tx_bytes[1] = a[15:8];
        tx_bytes[2] = a[7:0];
        for (int i = 0; i < len; i++) begin
            seed = xorshift(seed);
            tx_bytes[3 + i] = seed[7:0];
        end
        run_frame(3 + len, 0);
        ptr_model = a;
        for (int i = 0; i < len; i++) begin
            mem_model[ptr_model[7:0]] = tx_bytes[3 + i];
            ptr_model = ptr_model + 16'd1;
        end
        wr_count = wr_count + 7'(len);
    endtask

    task automatic addr_frame(input logic [15:0] a);
        tx_bytes[0] = 8'h02;
        tx_bytes[1] = a[15:8];
        tx_bytes[2] = a[7:0];
        run_frame(3, 0);
        ptr_model = a;
    endtask

    // Mode 3 read when with_addr is set, otherwise mode 1 at the pointer
    task automatic read_frame(input logic with_addr, input logic [15:0] a, input int len);
        int off;
        off = with_addr ? 3 : 1;
        tx_bytes[0] = {5'd0, len > 1, 1'b0, 1'b1} | (with_addr ? 8'h02 : 8'h00);
        tx_bytes[1] = a[15:8];
        tx_bytes[2] = a[7:0];
        for (int i = 0; i < len; i++)
            tx_bytes[off + i] = 8'h00;
        run_frame(off + len, 0);
        if (with_addr)
            ptr_model = a;
        for (int i = 0; i < len; i++) begin
            check_byte("miso read", mem_model[ptr_model[7:0]], rx_bytes[off + i]);
            ptr_model = ptr_model + 16'd1;
        end
    endtask

    task automatic host_traffic();
        while (!spi_done) begin
            host_seed = xorshift(host_seed);
            wait_cycles(int'(host_seed[11:8]));
            if (host_seed[12])
                host_write({1'b1, host_seed[6:0]}, host_seed[23:16]);
            else
                host_check({1'b1, host_seed[6:0]});
            host_count++;
        end
    endtask

    task automatic check_all_mem();
        for (int i = 0; i < spi_pkg::MEM_WORDS; i++)
            host_check(8'(i));
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == start_errors) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, errors - start_errors);
            tests_failed++;
        end
        start_errors = errors;
    endtask

    initial begin
        logic [15:0] a16;
        int          k;
        rst       <= 1'b0;
        sclk      <= 1'b0;
        ss        <= 1'b1;
        mosi      <= 1'b0;
        h_psel    <= 1'b0;
        h_penable <= 1'b0;
        h_pwrite  <= 1'b0;
        h_paddr   <= 8'h00;
        h_pwdata  <= 8'h00;
        seed = 32'h17fc5559;
        prev_err = 1'b0;
        wr_count = 7'd0;
        ptr_model = 16'd0;
        spi_done = 1'b0;
        errors = 0;
        checks = 0;
        start_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        host_count = 0;
        wait_cycles(3);
        rst <= 1'b1;
        wait_cycles(2);
        check_byte("busy", 8'd0, {7'd0, busy});
        check_byte("miso", 8'd0, {7'd0, miso});

        for (int i = 0; i < spi_pkg::MEM_WORDS; i++) begin
            seed = xorshift(seed);
            host_write(8'(i), seed[7:0]);
        end
        check_all_mem();
        end_test("host write and read back");

        for (int f = 0; f < 8; f++) begin
            seed = xorshift(seed);
            write_frame(seed[15:0], 1 + int'(seed[19:16]));
        end
        check_all_mem();
        end_test("SPI cont write frames");

        for (int r = 0; r < 4; r++) begin
            seed = xorshift(seed);
            addr_frame(seed[15:0]);
            read_frame(1'b0, 16'h0000, 1);
            read_frame(1'b0, 16'h0000, 2 + int'(seed[18:16]));
            seed = xorshift(seed);
            read_frame(1'b1, seed[15:0], 1 + int'(seed[19:16]));
        end
        end_test("SPI read frames");

        for (int f = 0; f < 3; f++) begin
            seed = xorshift(seed);
            write_frame(seed[15:0], 1 + int'(seed[19:16]));
        end
        tx_bytes[0] = 8'h00;
        run_frame(1, 0);
        end_test("status byte after writes");

        for (int r = 0; r < 3; r++) begin
            seed = xorshift(seed);
            k = 1 + int'(seed[18:16]) % 7;
            a16 = seed[15:0];
            tx_bytes[0] = 8'h0b;    // Write, mode 3, single byte
            tx_bytes[1] = a16[15:8];
            tx_bytes[2] = a16[7:0];
            tx_bytes[3] = seed[31:24];
            run_frame(4, k);
            ptr_model = a16;
            host_check(a16[7:0]);
            tx_bytes[0] = 8'h00;
            run_frame(1, 0);        // Bit 7 of this status shows the abort
        end
        end_test("aborted frames");

        host_seed = xorshift(seed ^ 32'h2b6d90e1);
        fork
            begin
                for (int f = 0; f < 6; f++) begin
                    seed = xorshift(seed);
                    write_frame({seed[15:8], 2'b00, seed[5:0]}, 1 + int'(seed[19:16]));
                end
                spi_done = 1'b1;
            end
            host_traffic();
        join
        check_all_mem();
        end_test($sformatf("host traffic during SPI writes (%0d transfers)", host_count));

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+tb
hdl/spi_pkg.sv
hdl/spi_frame_rx.sv
hdl/spi_bus_master.sv
hdl/apb_arbiter.sv
hdl/reg_mem.sv
hdl/spi_mem_bridge.sv
tb/tb_spi_mem_bridge.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the SPI-to-memory bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_spi_mem_bridge -o tb_spi_mem_bridge

out=$(./obj_dir/tb_spi_mem_bridge)
echo "$out"

if echo "$out" | grep -q '^>>> PASS$'; then
    exit 0
fi
exit 1
